// File: core_ctrl.sv
`timescale 1ns/1ps
`include "tenyr_params.svh"

module core_ctrl (
    input  logic                clk,
    input  logic                reset_n,
    input  logic [31:0]         i_insn_data,
    input  tenyr_pkg::decoded_t i_dec,
    input  logic [31:0]         i_result,
    input  logic [31:0]         i_z_value,
    output logic [31:0]         o_insn_addr,
    output logic [31:0]         o_pc_plus_one,
    output logic                o_exec_en,
    output logic                o_wr_en,
    output logic [3:0]          o_wr_index,
    output logic [31:0]         o_wr_data,
    output logic                o_halt,
    mem_req_if.master           mem
);

    import tenyr_pkg::*;

    ctrl_state_e state;
    logic [31:0] pc;
    logic [31:0] insn_q;       // Word captured in EXECUTE
    logic        req_valid_q;
    logic        store_z;
    logic        jump;

    assign o_insn_addr   = pc;
    assign o_pc_plus_one = pc + 32'd1;
    assign o_exec_en     = (state == EXECUTE) && (i_dec.kind == KIND_NORMAL);

    // Mode 10 addresses by Z, the others by the result
    assign store_z       = (i_dec.deref == DEREF_STORE_Z);
    assign mem.req_valid = req_valid_q;
    assign mem.req_write = store_z || (i_dec.deref == DEREF_STORE_RHS);
    assign mem.req_addr  = store_z ? i_z_value : i_result;
    assign mem.req_wdata = store_z ? i_result : i_z_value;

    assign o_wr_index = i_dec.z;
    assign o_wr_data  = (i_dec.deref == DEREF_LOAD) ? mem.rdata : i_result;
    assign o_wr_en    = (state == WRITEBACK) &&
                        (i_dec.deref inside {DEREF_NONE, DEREF_LOAD}) &&
                        (i_dec.z != `TENYR_ZERO_INDEX);
    assign jump       = o_wr_en && (i_dec.z == `TENYR_PC_INDEX);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state       <= FETCH;
            pc          <= `TENYR_RESET_VECTOR;
            req_valid_q <= 1'b0;
            o_halt      <= 1'b0;
        end else begin
            case (state)
                FETCH: state <= EXECUTE;  // ROM answers next cycle
                EXECUTE: begin
                    if (i_dec.kind == KIND_ILLEGAL) begin
                        o_halt <= 1'b1;
                        state  <= HALTED;
                    end else if (i_dec.deref != DEREF_NONE) begin
                        req_valid_q <= 1'b1;
                        state       <= MEMORY;
                    end else begin
                        state <= WRITEBACK;
                    end
                end
                MEMORY: begin
                    if (mem.done) begin
                        req_valid_q <= 1'b0;
                        if (mem.err) begin
                            o_halt <= 1'b1;
                            state  <= HALTED;
                        end else begin
                            state <= WRITEBACK;
                        end
                    end
                end
                WRITEBACK: begin
                    pc    <= jump ? o_wr_data : o_pc_plus_one;
                    state <= FETCH;
                end
                default: state <= HALTED;  // Only reset leaves here
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXECUTE)
            insn_q <= i_insn_data;
    end

    a_req_in_memory: assert property (@(posedge clk) disable iff (reset_n)
        mem.req_valid |-> state == MEMORY);

    a_no_zero_write: assert property (@(posedge clk) disable iff (reset_n)
        o_wr_en |-> o_wr_index != `TENYR_ZERO_INDEX);

    // Decode keeps reading the ROM while the PC holds
    a_insn_stable: assert property (@(posedge clk) disable iff (reset_n)
        state inside {MEMORY, WRITEBACK} |-> i_insn_data == insn_q);

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_en,
    input  tenyr_pkg::decoded_t i_dec,
    input  logic [31:0]         i_x_value,
    input  logic [31:0]         i_y_value,
    output logic [31:0]         o_result
);

    import tenyr_pkg::*;

    logic [31:0] operand;
    logic [31:0] addend;
    logic [31:0] op_value;

    // Type 1 puts the immediate inside the operation and adds Y
    assign operand = i_dec.itype ? i_dec.imm : i_y_value;
    assign addend  = i_dec.itype ? i_y_value : i_dec.imm;

    always_comb begin
        case (i_dec.op)
            OP_OR:   op_value = i_x_value | operand;
            OP_AND:  op_value = i_x_value & operand;
            OP_ADD:  op_value = i_x_value + operand;
            OP_MUL:  op_value = i_x_value * operand;  // Low word only
            OP_SHL:  op_value = (operand > 32'd31) ? '0 : i_x_value << operand[4:0];
            OP_LT:   op_value = {32{$signed(i_x_value) < $signed(operand)}};
            OP_EQ:   op_value = {32{i_x_value == operand}};
            OP_GT:   op_value = {32{$signed(i_x_value) > $signed(operand)}};
            OP_NAND: op_value = ~(i_x_value & operand);
            OP_XOR:  op_value = i_x_value ^ operand;
            OP_SUB:  op_value = i_x_value - operand;
            OP_XNOR: op_value = i_x_value ^ ~operand;
            OP_SHR:  op_value = (operand > 32'd31) ? '0 : i_x_value >> operand[4:0];
            default: op_value = '0;  // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n)
            o_result <= '0;
        else if (i_en)
            o_result <= op_value + addend;
    end

    // Sequencer must halt before executing an illegal word
    a_no_illegal_exec: assert property (@(posedge clk) disable iff (reset_n)
        i_en |-> i_dec.kind != KIND_ILLEGAL);

endmodule

// File: insn_decode.sv
`timescale 1ns/1ps

module insn_decode (
    input  logic [31:0]         i_insn,
    output tenyr_pkg::decoded_t o_dec
);

    import tenyr_pkg::*;

    always_comb begin
        o_dec = '0;

        casez (i_insn[31:28])
            4'b0???: o_dec.kind = KIND_NORMAL;
            4'b1111: o_dec.kind = KIND_ILLEGAL;
            default: o_dec.kind = KIND_NOP;  // 1000 to 1110
        endcase

        // Fields stay zero otherwise, so Z is never written
        if (o_dec.kind == KIND_NORMAL) begin
            o_dec.itype = i_insn[30];
            o_dec.deref = deref_e'(i_insn[29:28]);
            o_dec.z     = i_insn[27:24];
            o_dec.x     = i_insn[23:20];
            o_dec.y     = i_insn[19:16];
            o_dec.op    = op_e'(i_insn[15:12]);
            o_dec.imm   = {{20{i_insn[11]}}, i_insn[11:0]};  // Sign extend
        end
    end

endmodule

// File: list.f
+incdir+.
tenyr_pkg.sv
mem_req_if.sv
reg_file.sv
insn_decode.sv
exec_unit.sv
mem_port.sv
core_ctrl.sv
tenyr_core.sv
tb_tenyr_core.sv

// File: mem_port.sv
`timescale 1ns/1ps

module mem_port (
    input  logic        clk,
    input  logic        reset_n,
    mem_req_if.slave    mem,
    output logic [31:0] o_axi_awaddr,
    output logic        o_axi_awvalid,
    input  logic        i_axi_awready,
    output logic [31:0] o_axi_wdata,
    output logic [3:0]  o_axi_wstrb,
    output logic        o_axi_wvalid,
    input  logic        i_axi_wready,
    input  logic [1:0]  i_axi_bresp,
    input  logic        i_axi_bvalid,
    output logic        o_axi_bready,
    output logic [31:0] o_axi_araddr,
    output logic        o_axi_arvalid,
    input  logic        i_axi_arready,
    input  logic [31:0] i_axi_rdata,
    input  logic [1:0]  i_axi_rresp,
    input  logic        i_axi_rvalid,
    output logic        o_axi_rready
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic        busy;
    logic        done_q;
    logic        err_q;
    logic        start;
    logic [31:0] byte_addr_q;
    logic [31:0] wdata_q;
    logic [31:0] rdata_q;

    // Request is still high in the done cycle, so skip it
    assign start = mem.req_valid && !busy && !done_q;

    assign o_axi_awaddr = byte_addr_q;
    assign o_axi_araddr = byte_addr_q;
    assign o_axi_wdata  = wdata_q;
    assign o_axi_wstrb  = 4'hf;  // Full words only

    assign mem.done  = done_q;
    assign mem.err   = err_q;
    assign mem.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            busy          <= 1'b0;
            done_q        <= 1'b0;
            err_q         <= 1'b0;
            o_axi_awvalid <= 1'b0;
            o_axi_wvalid  <= 1'b0;
            o_axi_bready  <= 1'b0;
            o_axi_arvalid <= 1'b0;
            o_axi_rready  <= 1'b0;
        end else begin
            done_q <= 1'b0;

            if (start) begin
                busy          <= 1'b1;
                o_axi_awvalid <= mem.req_write;  // AW and W go out together
                o_axi_wvalid  <= mem.req_write;
                o_axi_bready  <= mem.req_write;
                o_axi_arvalid <= !mem.req_write;
                o_axi_rready  <= !mem.req_write;
            end

            // Each channel drops on its own handshake
            if (o_axi_awvalid && i_axi_awready)
                o_axi_awvalid <= 1'b0;
            if (o_axi_wvalid && i_axi_wready)
                o_axi_wvalid <= 1'b0;
            if (o_axi_arvalid && i_axi_arready)
                o_axi_arvalid <= 1'b0;

            if (o_axi_bready && i_axi_bvalid) begin
                o_axi_bready <= 1'b0;
                busy         <= 1'b0;
                done_q       <= 1'b1;
                err_q        <= (i_axi_bresp != RESP_OKAY);
            end

            if (o_axi_rready && i_axi_rvalid) begin
                o_axi_rready <= 1'b0;
                busy         <= 1'b0;
                done_q       <= 1'b1;
                err_q        <= (i_axi_rresp != RESP_OKAY);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            byte_addr_q <= {mem.req_addr[29:0], 2'b00};  // Word to byte address
            wdata_q     <= mem.req_wdata;
        end
        if (o_axi_rready && i_axi_rvalid)
            rdata_q <= i_axi_rdata;
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (reset_n)
        o_axi_awvalid && !i_axi_awready |=> o_axi_awvalid && $stable(o_axi_awaddr));

    a_w_stable: assert property (@(posedge clk) disable iff (reset_n)
        o_axi_wvalid && !i_axi_wready |=> o_axi_wvalid && $stable(o_axi_wdata));

    a_ar_stable: assert property (@(posedge clk) disable iff (reset_n)
        o_axi_arvalid && !i_axi_arready |=> o_axi_arvalid && $stable(o_axi_araddr));

endmodule

// File: mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;

    logic        req_valid;  // Held until done
    logic        req_write;
    logic [31:0] req_addr;   // Word address
    logic [31:0] req_wdata;
    logic        done;       // One cycle pulse
    logic [31:0] rdata;
    logic        err;        // Response was not OKAY

    modport master (
        output req_valid, req_write, req_addr, req_wdata,
        input  done, rdata, err
    );

    modport slave (
        input  req_valid, req_write, req_addr, req_wdata,
        output done, rdata, err
    );

endinterface

// File: reg_file.sv
`timescale 1ns/1ps
`include "tenyr_params.svh"

module reg_file (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [3:0]  i_x_index,
    input  logic [3:0]  i_y_index,
    input  logic [3:0]  i_z_index,
    input  logic [31:0] i_pc_plus_one,
    input  logic        i_wr_en,
    input  logic [3:0]  i_wr_index,
    input  logic [31:0] i_wr_data,
    output logic [31:0] o_x_value,
    output logic [31:0] o_y_value,
    output logic [31:0] o_z_value
);

    logic [31:0] regs [1:14];  // No storage behind 0 and 15

    function automatic logic [31:0] read_port(input logic [3:0] index);
        logic [31:0] value;
        if (index == `TENYR_ZERO_INDEX)
            value = '0;
        else if (index == `TENYR_PC_INDEX)
            value = i_pc_plus_one;  // P reads one past the current insn
        else
            value = regs[index];
        return value;
    endfunction

    always_comb begin
        o_x_value = read_port(i_x_index);
        o_y_value = read_port(i_y_index);
        o_z_value = read_port(i_z_index);
    end

    // PC writes are taken by the sequencer
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 1; i <= 14; i++)
                regs[i] <= '0;
        end else if (i_wr_en && i_wr_index != `TENYR_ZERO_INDEX &&
                     i_wr_index != `TENYR_PC_INDEX) begin
            regs[i_wr_index] <= i_wr_data;
        end
    end

endmodule

// File: tb_tenyr_core.sv
`timescale 1ns/1ps
`include "tenyr_params.svh"

module tb_tenyr_core;

    import tenyr_pkg::*;

    localparam int          TOTAL_WORDS = 182;  // Sum of all program lengths
    localparam logic [29:0] ERR_WORD    = 30'h0000_0bad;  // Slave answers SLVERR here

    logic        clk;
    logic        reset_n;
    logic [31:0] insn_data;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [31:0] rdata;
    logic [31:0] insn_addr, awaddr, wdata, araddr;
    logic [3:0]  wstrb;
    logic        halt, awvalid, wvalid, bready, arvalid, rready;

    logic [31:0] rom [256];
    logic [31:0] lfsr = 32'hde7e;
    logic [31:0] mem_dut [logic [29:0]];
    logic [31:0] mem_model [logic [29:0]];
    logic [31:0] exp_addr[$], exp_data[$], exp_fetch[$];
    logic [31:0] act_addr[$], act_data[$], act_fetch[$];
    logic [3:0]  act_strb[$];
    int          act_cycle[$];
    int          errors = 0;
    int          checks = 0;
    int          test_errors;
    int          cycle = 0;
    logic        seen;
    logic [31:0] last_addr;
    int          aw_wait, w_wait, ar_wait;
    logic        aw_have, w_have;
    logic [31:0] aw_q, w_q;

    tenyr_core u_dut (
        .clk (clk), .reset_n (reset_n),
        .o_insn_addr (insn_addr), .i_insn_data (insn_data), .o_halt (halt),
        .o_axi_awaddr (awaddr), .o_axi_awvalid (awvalid), .i_axi_awready (awready),
        .o_axi_wdata (wdata), .o_axi_wstrb (wstrb), .o_axi_wvalid (wvalid),
        .i_axi_wready (wready), .i_axi_bresp (bresp), .i_axi_bvalid (bvalid),
        .o_axi_bready (bready), .o_axi_araddr (araddr), .o_axi_arvalid (arvalid),
        .i_axi_arready (arready), .i_axi_rdata (rdata), .i_axi_rresp (rresp),
        .i_axi_rvalid (rvalid), .o_axi_rready (rready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] fill_word(input logic [29:0] word);
        logic [31:0] a;
        a = {2'b00, word};
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] mk(input logic t, input logic [1:0] d,
                                       input logic [3:0] z, input logic [3:0] x,
                                       input logic [3:0] y, input logic [3:0] op,
                                       input logic [11:0] imm);
        return {1'b0, t, d, z, x, y, op, imm};
    endfunction

    function automatic logic [3:0] rand_reg();
        logic [3:0] r;
        r = rand_bits(4);
        return (r == 4'd0 || r > 4'd13) ? 4'd1 + r[2:0] : r;  // 1 to 13
    endfunction

    function automatic logic [31:0] nop_word();
        logic [2:0] n;
        n = rand_bits(3);
        return {1'b1, (n == 3'd7) ? 3'd6 : n, 28'h0} | rand_bits(28);
    endfunction

    // ISA operations from the instruction set rules
    function automatic logic [31:0] alu(input logic [3:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
        case (op)
            4'h0: return a | b;
            4'h1: return a & b;
            4'h2: return a + b;
            4'h3: return a * b;
            4'h5: return (b >= 32) ? 32'd0 : a << b;
            4'h6: return ($signed(a) < $signed(b)) ? 32'hffff_ffff : 32'd0;
            4'h7: return (a == b) ? 32'hffff_ffff : 32'd0;
            4'h8: return ($signed(a) > $signed(b)) ? 32'hffff_ffff : 32'd0;
            4'h9: return ~(a & b);
            4'ha: return a ^ b;
            4'hb: return a - b;
            4'hc: return ~(a ^ b);
            4'hd: return (b >= 32) ? 32'd0 : a >> b;
            default: return 32'd0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic run_model();
        logic [31:0] regs [16];
        logic [31:0] pc, pc1, w, imm, xv, yv, zv, res, val;
        logic        wr;
        foreach (regs[i]) regs[i] = '0;
        pc = `TENYR_RESET_VECTOR;
        exp_addr.delete();
        exp_data.delete();
        exp_fetch.delete();
        mem_model.delete();
        for (int step = 0; step < 500; step++) begin
            exp_fetch.push_back(pc);
            w   = rom[pc[7:0]];
            pc1 = pc + 1;
            if (w[31:28] == 4'hf)
                break;
            if (w[31]) begin
                pc = pc1;
                continue;
            end
            regs[0]  = '0;
            regs[15] = pc1;
            imm = {{20{w[11]}}, w[11:0]};
            xv  = regs[w[23:20]];
            yv  = regs[w[19:16]];
            zv  = regs[w[27:24]];
            res = alu(w[15:12], xv, w[30] ? imm : yv) + (w[30] ? yv : imm);
            wr  = 1'b0;
            case (w[29:28])
                2'd0: begin
                    val = res;
                    wr  = 1'b1;
                end
                2'd1: begin
                    if (res[29:0] == ERR_WORD)
                        break;  // Error response halts
                    val = mem_model.exists(res[29:0]) ? mem_model[res[29:0]]
                                                      : fill_word(res[29:0]);
                    wr  = 1'b1;
                end
                2'd2: begin
                    exp_addr.push_back({zv[29:0], 2'b00});
                    exp_data.push_back(res);
                    mem_model[zv[29:0]] = res;
                end
                default: begin
                    exp_addr.push_back({res[29:0], 2'b00});
                    exp_data.push_back(zv);
                    mem_model[res[29:0]] = zv;
                end
            endcase
            if (wr && w[27:24] == 4'd15) begin
                pc = val;  // Jump
            end else begin
                if (wr && w[27:24] != 4'd0)
                    regs[w[27:24]] = val;
                pc = pc1;
            end
        end
    endtask

    task automatic clear_rom();
        for (int i = 0; i < 256; i++)
            rom[i] = 32'hf000_0000 | i;  // Illegal everywhere
    endtask

    task automatic run_test(input string name, input bit check_mem, input bit check_timing);
        logic [31:0] hold;
        test_errors = 0;
        run_model();
        @(posedge clk);
        reset_n <= 1'b1;
        repeat (5) @(posedge clk);
        act_addr.delete();
        act_data.delete();
        act_strb.delete();
        act_fetch.delete();
        act_cycle.delete();
        mem_dut.delete();
        reset_n <= 1'b0;
        #1;
        check_value({name, " reset pc"}, `TENYR_RESET_VECTOR, insn_addr);
        check_value({name, " reset halt"}, 0, halt);
        check_value({name, " reset valid"}, 0, {awvalid, wvalid, arvalid});
        while (!halt)
            @(posedge clk);
        hold = insn_addr;
        repeat (20) @(posedge clk);
        check_value({name, " halted pc"}, hold, insn_addr);
        check_value({name, " store count"}, exp_addr.size(), act_addr.size());
        check_value({name, " data count"}, exp_data.size(), act_data.size());
        for (int i = 0; i < exp_addr.size() && i < act_addr.size(); i++)
            check_value({name, " awaddr"}, exp_addr[i], act_addr[i]);
        for (int i = 0; i < exp_data.size() && i < act_data.size(); i++)
            check_value({name, " wdata"}, exp_data[i], act_data[i]);
        for (int i = 0; i < act_strb.size(); i++)
            check_value({name, " wstrb"}, 4'hf, act_strb[i]);
        check_value({name, " fetch count"}, exp_fetch.size(), act_fetch.size());
        for (int i = 0; i < exp_fetch.size() && i < act_fetch.size(); i++)
            check_value({name, " fetch addr"}, exp_fetch[i], act_fetch[i]);
        if (check_mem) begin
            foreach (mem_model[k])
                check_value({name, " memory"}, mem_model[k],
                            mem_dut.exists(k) ? mem_dut[k] : fill_word(k));
        end
        if (check_timing) begin
            for (int i = 1; i < act_cycle.size(); i++)
                check_value({name, " fetch spacing"}, 3, act_cycle[i] - act_cycle[i - 1]);
        end
        $display("test %s: %s", name, (test_errors == 0) ? "pass" : "fail");
    endtask

    // Instruction ROM, one cycle read
    always @(posedge clk)
        insn_data <= rom[insn_addr[7:0]];

    // Fetch address monitor
    always @(posedge clk) begin
        cycle++;
        if (reset_n) begin
            seen <= 1'b0;
        end else if (!seen || insn_addr != last_addr) begin
            act_fetch.push_back(insn_addr);
            act_cycle.push_back(cycle);
            last_addr = insn_addr;
            seen <= 1'b1;
        end
    end

    // AXI4-Lite slave memory with random ready delays
    always @(posedge clk) begin
        if (reset_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            aw_wait <= 0;
            w_wait  <= 0;
            ar_wait <= 0;
        end else begin
            if (awvalid && !awready) begin
                if (aw_wait == 0) awready <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_q    <= awaddr;
                aw_have <= 1'b1;
                aw_wait <= rand_bits(2);
                act_addr.push_back(awaddr);
            end
            if (wvalid && !wready) begin
                if (w_wait == 0) wready <= 1'b1;
                else w_wait <= w_wait - 1;
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_q    <= wdata;
                w_have <= 1'b1;
                w_wait <= rand_bits(2);
                act_data.push_back(wdata);
                act_strb.push_back(wstrb);
            end
            if (aw_have && w_have && !bvalid) begin
                mem_dut[aw_q[31:2]] = w_q;
                bvalid  <= 1'b1;
                bresp   <= 2'b00;
                aw_have <= 1'b0;
                w_have  <= 1'b0;
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (arvalid && !arready) begin
                if (ar_wait == 0) arready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_wait <= rand_bits(2);
                rvalid  <= 1'b1;
                rresp   <= (araddr[31:2] == ERR_WORD) ? 2'b10 : 2'b00;
                rdata   <= mem_dut.exists(araddr[31:2]) ? mem_dut[araddr[31:2]]
                                                        : fill_word(araddr[31:2]);
            end
            if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    initial begin
        repeat (TOTAL_WORDS * 40) @(posedge clk);
        $display("Timeout: the core stopped making progress");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int n;
        reset_n   = 1'b1;
        insn_data = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        arready   = 1'b0;
        bvalid    = 1'b0;
        rvalid    = 1'b0;
        bresp     = 2'b00;
        rresp     = 2'b00;
        rdata     = '0;

        // Every opcode in both types, each result stored through r14
        clear_rom();
        n = 0;
        for (int r = 1; r <= 13; r++)
            rom[n++] = mk(1, 0, r, 0, 0, OP_ADD, rand_bits(12));
        rom[n++] = mk(0, 0, 14, 0, 0, OP_OR, 12'h200);
        for (int op = 0; op < 16; op++) begin
            for (int t = 0; t < 2; t++) begin
                logic [3:0] z;
                z = rand_reg();
                rom[n++] = mk(t, 0, z, rand_bits(4), rand_bits(4), op, rand_bits(12));
                rom[n++] = mk(0, 2, 14, z, 0, OP_OR, 12'h000);
            end
        end
        run_test("arithmetic", 1'b0, 1'b0);

        clear_rom();
        rom[0] = mk(0, 0, 0, 0, 0, OP_ADD, 12'h007);   // r0 stays zero
        rom[1] = mk(0, 0, 1, 0, 0, OP_ADD, 12'h040);
        rom[2] = mk(0, 2, 1, 0, 0, OP_OR, 12'h000);
        rom[3] = mk(0, 2, 1, 15, 0, OP_OR, 12'h000);   // Stores 4
        rom[4] = mk(0, 0, 15, 15, 0, OP_ADD, 12'h002); // Jump to 7
        rom[5] = mk(0, 2, 1, 0, 0, OP_OR, 12'h055);
        rom[7] = mk(0, 2, 1, 0, 0, OP_OR, 12'h077);
        run_test("zero_and_pc", 1'b0, 1'b0);

        // Random deref modes mixed with no-ops
        clear_rom();
        n = 0;
        for (int r = 1; r <= 13; r++)
            rom[n++] = mk(1, 0, r, 0, 0, OP_ADD, rand_bits(12));
        for (int i = 0; i < 40; i++) begin
            if (rand_bits(3) == 3'd0)
                rom[n++] = nop_word();
            else
                rom[n++] = mk(rand_bits(1), rand_bits(2), rand_reg(), rand_bits(4),
                              rand_bits(4), rand_bits(4), rand_bits(12));
        end
        run_test("load_store", 1'b1, 1'b0);

        clear_rom();
        for (int i = 0; i < 20; i++)
            rom[i] = (i % 5 == 4) ? nop_word()
                                  : mk(rand_bits(1), 0, rand_reg(), rand_bits(4),
                                       rand_bits(4), rand_bits(4), rand_bits(12));
        run_test("timing", 1'b0, 1'b1);

        clear_rom();
        rom[0] = mk(0, 0, 1, 0, 0, OP_ADD, 12'h080);
        rom[1] = mk(0, 2, 1, 0, 0, OP_OR, 12'h011);
        rom[2] = 32'hf123_4567;
        rom[3] = mk(0, 2, 1, 0, 0, OP_OR, 12'h022);
        run_test("illegal_halt", 1'b0, 1'b0);

        // 0x5d6 twice plus one gives the error word
        clear_rom();
        rom[0] = mk(1, 0, 1, 0, 0, OP_ADD, 12'h5d6);
        rom[1] = mk(0, 0, 2, 1, 1, OP_ADD, 12'h001);
        for (int i = 0; i < 7; i++)
            rom[2 + i] = {4'h8 + i[3:0], 28'h0} | rand_bits(28);
        rom[9]  = mk(0, 0, 3, 0, 0, OP_ADD, 12'h060);
        rom[10] = mk(0, 2, 3, 2, 0, OP_OR, 12'h000);
        rom[11] = mk(0, 1, 4, 2, 0, OP_OR, 12'h000);
        rom[12] = mk(0, 2, 3, 0, 0, OP_OR, 12'h033);
        run_test("slverr_halt", 1'b0, 1'b0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: tenyr_core.sv
`timescale 1ns/1ps

module tenyr_core (
    input  logic        clk,
    input  logic        reset_n,
    output logic [31:0] o_insn_addr,
    input  logic [31:0] i_insn_data,
    output logic        o_halt,
    output logic [31:0] o_axi_awaddr,
    output logic        o_axi_awvalid,
    input  logic        i_axi_awready,
    output logic [31:0] o_axi_wdata,
    output logic [3:0]  o_axi_wstrb,
    output logic        o_axi_wvalid,
    input  logic        i_axi_wready,
    input  logic [1:0]  i_axi_bresp,
    input  logic        i_axi_bvalid,
    output logic        o_axi_bready,
    output logic [31:0] o_axi_araddr,
    output logic        o_axi_arvalid,
    input  logic        i_axi_arready,
    input  logic [31:0] i_axi_rdata,
    input  logic [1:0]  i_axi_rresp,
    input  logic        i_axi_rvalid,
    output logic        o_axi_rready
);

    import tenyr_pkg::*;

    decoded_t    dec;
    logic [31:0] x_value;
    logic [31:0] y_value;
    logic [31:0] z_value;
    logic [31:0] result;
    logic [31:0] pc_plus_one;
    logic        exec_en;
    logic        wr_en;
    logic [3:0]  wr_index;
    logic [31:0] wr_data;

    mem_req_if u_mem_if ();

    core_ctrl u_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_insn_data   (i_insn_data),
        .i_dec         (dec),
        .i_result      (result),
        .i_z_value     (z_value),
        .o_insn_addr   (o_insn_addr),
        .o_pc_plus_one (pc_plus_one),
        .o_exec_en     (exec_en),
        .o_wr_en       (wr_en),
        .o_wr_index    (wr_index),
        .o_wr_data     (wr_data),
        .o_halt        (o_halt),
        .mem           (u_mem_if.master)
    );

    // Decoder reads the ROM directly since the address holds per insn
    insn_decode u_decode (
        .i_insn (i_insn_data),
        .o_dec  (dec)
    );

    reg_file u_regs (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_x_index     (dec.x),
        .i_y_index     (dec.y),
        .i_z_index     (dec.z),
        .i_pc_plus_one (pc_plus_one),
        .i_wr_en       (wr_en),
        .i_wr_index    (wr_index),
        .i_wr_data     (wr_data),
        .o_x_value     (x_value),
        .o_y_value     (y_value),
        .o_z_value     (z_value)
    );

    exec_unit u_exec (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_en      (exec_en),
        .i_dec     (dec),
        .i_x_value (x_value),
        .i_y_value (y_value),
        .o_result  (result)
    );

    mem_port u_mem_port (
        .clk           (clk),
        .reset_n       (reset_n),
        .mem           (u_mem_if.slave),
        .o_axi_awaddr  (o_axi_awaddr),
        .o_axi_awvalid (o_axi_awvalid),
        .i_axi_awready (i_axi_awready),
        .o_axi_wdata   (o_axi_wdata),
        .o_axi_wstrb   (o_axi_wstrb),
        .o_axi_wvalid  (o_axi_wvalid),
        .i_axi_wready  (i_axi_wready),
        .i_axi_bresp   (i_axi_bresp),
        .i_axi_bvalid  (i_axi_bvalid),
        .o_axi_bready  (o_axi_bready),
        .o_axi_araddr  (o_axi_araddr),
        .o_axi_arvalid (o_axi_arvalid),
        .i_axi_arready (i_axi_arready),
        .i_axi_rdata   (i_axi_rdata),
        .i_axi_rresp   (i_axi_rresp),
        .i_axi_rvalid  (i_axi_rvalid),
        .o_axi_rready  (o_axi_rready)
    );

endmodule

// File: tenyr_params.svh
`ifndef TENYR_PARAMS_SVH
`define TENYR_PARAMS_SVH

// First fetch address after reset
`define TENYR_RESET_VECTOR 32'h0000_0000

// Register that always reads as zero
`define TENYR_ZERO_INDEX 4'd0

// Program counter in the register space
`define TENYR_PC_INDEX 4'd15

`endif

// File: tenyr_pkg.sv
package tenyr_pkg;

    typedef enum logic [3:0] {
        OP_OR     = 4'b0000,
        OP_AND    = 4'b0001,
        OP_ADD    = 4'b0010,
        OP_MUL    = 4'b0011,
        OP_RSVD4  = 4'b0100,
        OP_SHL    = 4'b0101,
        OP_LT     = 4'b0110,
        OP_EQ     = 4'b0111,
        OP_GT     = 4'b1000,
        OP_NAND   = 4'b1001,
        OP_XOR    = 4'b1010,
        OP_SUB    = 4'b1011,
        OP_XNOR   = 4'b1100,
        OP_SHR    = 4'b1101,
        OP_RSVD14 = 4'b1110,
        OP_RSVD15 = 4'b1111
    } op_e;

    typedef enum logic [1:0] {
        DEREF_NONE      = 2'b00,  // Z <- rhs
        DEREF_LOAD      = 2'b01,  // Z <- [rhs]
        DEREF_STORE_Z   = 2'b10,  // [Z] <- rhs
        DEREF_STORE_RHS = 2'b11   // [rhs] <- Z
    } deref_e;

    typedef enum logic [1:0] {
        KIND_NORMAL  = 2'd0,
        KIND_NOP     = 2'd1,
        KIND_ILLEGAL = 2'd2
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        logic        itype;   // Swaps Y and the immediate
        deref_e      deref;
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        op_e         op;
        logic [31:0] imm;
    } decoded_t;

    typedef enum logic [2:0] {
        FETCH,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } ctrl_state_e;

endpackage
